// ==== dv/memory_loader_properties.sv ====
`default_nettype none

module memory_loader_properties (
   input logic clk,
   input logic rst_n,
   input logic ram_ce,
   input logic sdram_ready,
   input logic ddr3_rd,
   input logic ddr3_ready,
   input logic need_byte,
   input logic fill_start,
   input logic fill_done
);
   timeunit 1ns;
   timeprecision 1ps;

   logic in_fill;   // between fill_start and fill_done
   int   assert_fails = 0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_fill <= 1'b0;
      end else if (fill_start) begin
         in_fill <= 1'b1;
      end else if (fill_done) begin
         in_fill <= 1'b0;
      end
   end

   ce_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
      ram_ce |-> sdram_ready)
      else begin
         assert_fails++;
         $error("ram_ce high while sdram_ready is low");
      end

   rd_held: assert property (@(posedge clk) disable iff (!rst_n)
      ddr3_rd && !ddr3_ready |=> ddr3_rd)
      else begin
         assert_fails++;
         $error("ddr3_rd dropped before ddr3_ready");
      end

   need_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      need_byte |-> in_fill)
      else begin
         assert_fails++;
         $error("need_byte high outside a fill");
      end

endmodule

bind memory_loader memory_loader_properties u_properties (
   .clk         (clk),
   .rst_n       (rst_n),
   .ram_ce      (ram_ce),
   .sdram_ready (sdram_ready),
   .ddr3_rd     (ddr3_rd),
   .ddr3_ready  (ddr3_ready),
   .need_byte   (need_byte),
   .fill_start  (fill_start),
   .fill_done   (fill_done)
);

`default_nettype wire

// ==== dv/memory_loader_tb.sv ====
`default_nettype none

module memory_loader_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import msx_loader_pkg::*;

   localparam int     n_tests    = 16;
   localparam int     max_image  = 5 * (16 + KBD_SKIP);
   localparam longint timeout_ns = 64'(n_tests) * (200 + max_image * 8) * 10;

   logic         clk;
   logic         rst_n;
   logic         ioctl_download;
   logic [15:0]  ioctl_index;
   logic [26:0]  ioctl_addr;
   logic [27:0]  ddr3_addr;
   logic         ddr3_rd;
   logic [7:0]   ddr3_dout;
   logic         ddr3_ready;
   logic [26:0]  ram_addr;
   logic [7:0]   ram_din;
   logic         ram_ce;
   logic         sdram_ready;
   logic         reset_rq;
   slot_block_t  slot_layout [64];
   lookup_ram_t  lookup_ram [16];
   bios_config_t bios_config;

   logic [7:0]   ddr_mem [4096];
   logic [7:0]   ram_mem [512];
   logic [7:0]   exp_ram [512];
   slot_block_t  exp_slot [64];
   lookup_ram_t  exp_lookup [16];
   bios_config_t exp_bios;
   int           exp_regions;
   int           exp_ram_end;
   int           exp_end_addr;
   int           ram_writes;
   bit           gaps;
   int           checks;
   int           errors;
   int           total_errors;

   memory_loader #(
      .size_unit_log2 (4)
   ) UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .ddr3_addr      (ddr3_addr),
      .ddr3_rd        (ddr3_rd),
      .ddr3_dout      (ddr3_dout),
      .ddr3_ready     (ddr3_ready),
      .ram_addr       (ram_addr),
      .ram_din        (ram_din),
      .ram_ce         (ram_ce),
      .sdram_ready    (sdram_ready),
      .reset_rq       (reset_rq),
      .slot_layout    (slot_layout),
      .lookup_ram     (lookup_ram),
      .bios_config    (bios_config)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ddr3 and sdram models with ready gaps and ram write capture
   always @(negedge clk) begin : bus_models
      logic rdy;
      rdy = gaps ? ($urandom % 4 != 0) : 1'b1;
      if (ddr3_rd && rdy) begin
         ddr3_dout = ddr_mem[ddr3_addr[11:0]];  // read accepted at next edge
      end
      ddr3_ready  = rdy;
      sdram_ready = gaps ? ($urandom % 3 != 0) : 1'b1;
      #1;
      if (ram_ce) begin
         ram_mem[ram_addr[8:0]] = ram_din;
         ram_writes++;
      end
   end

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic logic [7:0] pattern_byte(input logic [2:0] pat, input logic [8:0] ofs);
      case (pat)
         3'd1, 3'd5, 3'd6, 3'd7: return 8'hff;
         3'd3: return (ofs[8] == ofs[1]) ? 8'hff : 8'h00;
         3'd4: return (ofs[8] != ofs[0]) ? 8'hff : 8'h00;
         default: return 8'h00;
      endcase
   endfunction

   // random image into ddr_mem and expected tables alongside
   task automatic build_image(input int n_rec, input bit corrupt, output int size);
      logic [7:0]  hdr [16];
      slot_block_t old_slot [64];
      int          addr;
      int          bad;
      int          ref_cnt;
      int          bytes;
      int          units;
      int          sel;
      bit          stopped;
      bit          has_data;
      bit          copy;
      logic [1:0]  par;
      logic [3:0]  ref_sel;
      logic [5:0]  idx;
      addr        = 0;
      ref_cnt     = 0;
      stopped     = 1'b0;
      bad         = corrupt ? 1 + $urandom % (n_rec - 1) : n_rec;
      exp_ram_end = 0;
      exp_bios    = '0;
      for (int i = 0; i < 64; i++) begin
         exp_slot[i] = '{MAPPER_UNUSED, DEVICE_NONE, 4'd0, 2'd0};
      end
      for (int i = 0; i < 512; i++) begin
         exp_ram[i] = 'x;
      end
      for (int r = 0; r < n_rec; r++) begin
         for (int i = 0; i < 16; i++) begin
            hdr[i] = 8'($urandom);
         end
         {hdr[0], hdr[1], hdr[2]} = MAGIC;
         sel = $urandom % 6;
         hdr[3][7:4] = (sel < 4) ? REC_INTERNAL : (sel == 4) ? REC_CONFIG : REC_KBD_LAYOUT;
         bytes = (sel == 5) ? KBD_SKIP : 0;
         units = 0;
         if (sel < 4) begin
            sel    = $urandom % 3;
            hdr[4] = (sel == 0) ? ID_NONE : (sel == 1) ? ID_RAM : 8'd2 + 8'($urandom % 254);
            hdr[5] = hdr[5] & 8'hf8;
            hdr[6] = 8'($urandom % 4);
            units  = (hdr[4] != ID_NONE) ? hdr[6] : 0;
            if (hdr[4] != ID_RAM) begin
               bytes = units * 16;
            end
         end
         if (r == bad) begin
            hdr[1]       = hdr[1] ^ 8'h01;  // broken magic
            stopped      = 1'b1;
            exp_end_addr = addr + 16;
         end
         for (int i = 0; i < 16; i++) begin
            ddr_mem[addr + i] = hdr[i];
         end
         for (int i = 0; i < bytes; i++) begin
            ddr_mem[addr + 16 + i] = 8'($urandom);
         end
         if (!stopped && hdr[3][7:4] == REC_CONFIG) begin
            exp_bios.slot_expander_en = hdr[4][3:0];
            exp_bios.msx_typ          = hdr[4][5:4];
         end
         if (!stopped && hdr[3][7:4] == REC_INTERNAL) begin
            has_data = hdr[4] != ID_NONE;
            copy     = hdr[4] != ID_RAM;
            if (hdr[4] == ID_RAM && hdr[6] > exp_bios.ram_size) begin
               exp_bios.ram_size = hdr[6];
            end
            if (units != 0) begin
               exp_lookup[ref_cnt] = '{27'(exp_ram_end), 16'(units), copy};
               for (int o = 0; o < units * 16; o++) begin
                  exp_ram[exp_ram_end + o] = copy ? ddr_mem[addr + 16 + o]
                                                  : pattern_byte(hdr[11][2:0], 9'(o));
               end
               exp_ram_end += units * 16;
            end
            ref_sel  = has_data ? 4'(ref_cnt) : 4'd0;
            old_slot = exp_slot;
            for (int b = 0; b < 4; b++) begin
               idx = {hdr[3][3:0], 2'(b)};
               par = hdr[10][2*b +: 2];
               case (hdr[9][2*b +: 2])
                  2'd1: exp_slot[idx] = old_slot[{hdr[3][3:0], par}];
                  2'd2: exp_slot[idx] = '{hdr[8], hdr[7], ref_sel, par};
                  2'd3: exp_slot[idx] = '{MAPPER_UNUSED, hdr[7], ref_sel, par};
                  default: ;
               endcase
            end
            if (units != 0) begin
               ref_cnt++;
            end
         end
         addr += 16 + bytes;
      end
      size        = addr;
      exp_regions = ref_cnt;
      if (!stopped) begin
         exp_end_addr = addr;
      end
   endtask

   task automatic compare_results();
      check_value(ddr3_addr, exp_end_addr, "ddr3_addr at end of walk");
      check_value(ddr3_rd, 1'b0, "ddr3_rd after walk");
      check_value(ram_writes, exp_ram_end, "number of ram writes");
      for (int i = 0; i < exp_ram_end; i++) begin
         check_value(ram_mem[i], exp_ram[i], $sformatf("ram byte %0d", i));
      end
      for (int i = 0; i < exp_regions; i++) begin
         check_value(lookup_ram[i], exp_lookup[i], $sformatf("lookup_ram[%0d]", i));
      end
      for (int i = 0; i < 64; i++) begin
         check_value(slot_layout[i], exp_slot[i], $sformatf("slot_layout[%0d]", i));
      end
      check_value(bios_config, exp_bios, "bios_config");
   endtask

   task automatic run_test(input int t);
      int n_rec;
      int size;
      int err0;
      bit corrupt;
      n_rec   = 2 + $urandom % 4;
      corrupt = (t % 4 == 3);
      gaps    = (t % 2 == 1);
      err0    = errors;
      for (int i = 0; i < 512; i++) begin
         ram_mem[i] = 'x;
      end
      build_image(n_rec, corrupt, size);
      ram_writes = 0;
      @(negedge clk);
      ioctl_index    = 16'd1;
      ioctl_addr     = 27'd0;
      ioctl_download = 1'b1;
      repeat (4) @(negedge clk);
      ioctl_addr = 27'(size);  // final upload address
      @(negedge clk);
      ioctl_download = 1'b0;
      @(negedge clk);
      check_value(reset_rq, 1'b0, "reset_rq one cycle after upload end");
      @(negedge clk);
      check_value(reset_rq, 1'b1, "reset_rq one cycle after load");
      while (reset_rq) begin
         @(negedge clk);
      end
      compare_results();
      $display("test %0d done: %0d records, gaps %0d, bad magic %0d, %0d errors",
               t, n_rec, gaps, corrupt, errors - err0);
   endtask

   initial begin
      #(timeout_ns);
      $display("watchdog: walk did not end within %0d ns", timeout_ns);
      $display("Regression failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h69e5));
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = 27'd0;
      ddr3_dout      = 8'd0;
      ddr3_ready     = 1'b0;
      sdram_ready    = 1'b0;
      gaps           = 1'b0;
      checks         = 0;
      errors         = 0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      check_value(reset_rq, 1'b0, "reset_rq after reset");
      check_value(ram_ce, 1'b0, "ram_ce after reset");
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      total_errors = errors + UUT.u_properties.assert_fails;
      $display("%0d tests, %0d checks, %0d errors", n_tests, checks, total_errors);
      if (total_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/fill_engine.sv ====
`default_nettype none

module fill_engine #(
   parameter int size_unit_log2 = 14,
   parameter int ram_aw         = 27
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        fill_start,
   input  msx_loader_pkg::fill_cmd_t   fill_cmd,
   input  logic                        byte_valid,
   input  logic [7:0]                  fill_byte,
   input  logic                        sdram_ready,
   output logic                        need_byte,
   output logic                        fill_done,
   output logic [ram_aw-1:0]           ram_addr,
   output logic [7:0]                  ram_din,
   output logic                        ram_ce,
   output msx_loader_pkg::lookup_ram_t lookup_ram [16]
);
   import msx_loader_pkg::*;

   localparam int cnt_w = 11 + size_unit_log2;

   fill_cmd_t         cmd;
   logic              busy;
   logic              have_byte;
   logic              ce_q;
   logic              start_nz;
   logic [cnt_w-1:0]  remaining;
   logic [8:0]        offset;      // low bits of position in region
   logic [7:0]        data_q;
   logic [7:0]        pat_byte;
   logic [ram_aw-1:0] base;

   assign start_nz  = fill_start & (fill_cmd.size_units != 11'd0);
   assign base      = (fill_cmd.ref_ram == 4'd0) ? '0 : ram_addr;  // first region at 0
   assign need_byte = busy & cmd.copy & ~have_byte;
   assign ram_ce    = busy & sdram_ready & ~ce_q & (have_byte | ~cmd.copy);
   assign ram_din   = cmd.copy ? data_q : pat_byte;

   always_comb begin
      case (cmd.pattern)
         3'd1, 3'd5, 3'd6, 3'd7: pat_byte = 8'hff;
         3'd3: pat_byte = (offset[8] == offset[1]) ? 8'hff : 8'h00;  // checkerboard
         3'd4: pat_byte = (offset[8] != offset[0]) ? 8'hff : 8'h00;
         default: pat_byte = 8'h00;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy      <= 1'b0;
         have_byte <= 1'b0;
         ce_q      <= 1'b0;
         fill_done <= 1'b0;
         ram_addr  <= '0;
      end else begin
         ce_q      <= ram_ce;
         fill_done <= fill_start & (fill_cmd.size_units == 11'd0);  // empty region
         if (byte_valid) begin
            have_byte <= 1'b1;
         end
         if (start_nz) begin
            busy     <= 1'b1;
            ram_addr <= base;
         end else if (ram_ce) begin
            ram_addr  <= ram_addr + 1'b1;
            have_byte <= 1'b0;
            if (remaining == cnt_w'(1)) begin
               busy      <= 1'b0;
               fill_done <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_start) begin
         cmd       <= fill_cmd;
         remaining <= cnt_w'(fill_cmd.size_units) << size_unit_log2;
         offset    <= 9'd0;
      end else if (ram_ce) begin
         remaining <= remaining - 1'b1;
         offset    <= offset + 9'd1;
      end
      if (start_nz) begin
         lookup_ram[fill_cmd.ref_ram] <= '{
            addr: 27'(base),
            size: 16'(fill_cmd.size_units),
            ro:   fill_cmd.copy
         };
      end
      if (byte_valid) begin
         data_q <= fill_byte;
      end
   end

endmodule

`default_nettype wire

// ==== src/memory_loader.sv ====
`default_nettype none

module memory_loader #(
   parameter int size_unit_log2 = 14,
   parameter int ram_aw         = 27
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic [26:0]                  ioctl_addr,
   output logic [27:0]                  ddr3_addr,
   output logic                         ddr3_rd,
   input  logic [7:0]                   ddr3_dout,
   input  logic                         ddr3_ready,
   output logic [ram_aw-1:0]            ram_addr,
   output logic [7:0]                   ram_din,
   output logic                         ram_ce,
   input  logic                         sdram_ready,
   output logic                         reset_rq,
   output msx_loader_pkg::slot_block_t  slot_layout [64],
   output msx_loader_pkg::lookup_ram_t  lookup_ram [16],
   output msx_loader_pkg::bios_config_t bios_config
);
   import msx_loader_pkg::*;

   logic [26:0] image_size;
   logic        load;
   logic        fill_start;
   fill_cmd_t   fill_cmd;
   logic        need_byte;
   logic        fill_done;
   logic        byte_valid;
   logic [7:0]  fill_byte;
   logic        slot_store;
   slot_cmd_t   slot_cmd;
   logic        slot_clear;
   logic        clear_done;

   upload_tracker u_upload_tracker (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .image_size     (image_size),
      .load           (load)
   );

   record_walker u_record_walker (
      .clk         (clk),
      .rst_n       (rst_n),
      .load        (load),
      .image_size  (image_size),
      .ddr3_dout   (ddr3_dout),
      .ddr3_ready  (ddr3_ready),
      .ddr3_addr   (ddr3_addr),
      .ddr3_rd     (ddr3_rd),
      .reset_rq    (reset_rq),
      .bios_config (bios_config),
      .fill_start  (fill_start),
      .fill_cmd    (fill_cmd),
      .need_byte   (need_byte),
      .fill_done   (fill_done),
      .byte_valid  (byte_valid),
      .fill_byte   (fill_byte),
      .slot_store  (slot_store),
      .slot_cmd    (slot_cmd),
      .slot_clear  (slot_clear),
      .clear_done  (clear_done)
   );

   fill_engine #(
      .size_unit_log2 (size_unit_log2),
      .ram_aw         (ram_aw)
   ) u_fill_engine (
      .clk         (clk),
      .rst_n       (rst_n),
      .fill_start  (fill_start),
      .fill_cmd    (fill_cmd),
      .byte_valid  (byte_valid),
      .fill_byte   (fill_byte),
      .sdram_ready (sdram_ready),
      .need_byte   (need_byte),
      .fill_done   (fill_done),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_ce      (ram_ce),
      .lookup_ram  (lookup_ram)
   );

   slot_table u_slot_table (
      .clk         (clk),
      .rst_n       (rst_n),
      .slot_clear  (slot_clear),
      .slot_store  (slot_store),
      .slot_cmd    (slot_cmd),
      .clear_done  (clear_done),
      .slot_layout (slot_layout)
   );

endmodule

`default_nettype wire

// ==== src/msx_loader_pkg.sv ====
`default_nettype none

package msx_loader_pkg;

   // record kind in the high nibble of header byte 3
   typedef enum logic [3:0] {
      REC_INTERNAL   = 4'd1,
      REC_CONFIG     = 4'd2,
      REC_KBD_LAYOUT = 4'd3
   } rec_kind_t;

   // any region source not listed here is a rom image in ddr3
   typedef enum logic [7:0] {
      ID_NONE = 8'd0,
      ID_RAM  = 8'd1,
      ID_ROM  = 8'd2
   } data_id_t;

   localparam logic [23:0] MAGIC         = 24'h4d5358;  // "MSX"
   localparam logic [7:0]  MAPPER_UNUSED = 8'hff;
   localparam logic [7:0]  DEVICE_NONE   = 8'h00;
   localparam int          KBD_SKIP      = 512;         // layout payload after header

   typedef struct packed {
      logic [7:0] mapper;
      logic [7:0] device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;
   } slot_block_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;   // in size units
      logic        ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [7:0] ram_size;
      logic [3:0] slot_expander_en;
      logic [1:0] msx_typ;
   } bios_config_t;

   typedef struct packed {
      logic [10:0] size_units;
      logic [2:0]  pattern;
      logic        copy;   // bytes come from ddr3
      logic [3:0]  ref_ram;
   } fill_cmd_t;

   typedef struct packed {
      logic [3:0] slot_subslot;
      logic [7:0] mode;    // 2 bits per block
      logic [7:0] param;   // 2 bits per block
      logic [7:0] mapper;
      logic [7:0] device;
      logic [3:0] ref_ram;
      logic       has_data;
   } slot_cmd_t;

endpackage

`default_nettype wire

// ==== src/record_walker.sv ====
`default_nettype none

module record_walker (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         load,
   input  logic [26:0]                  image_size,
   input  logic [7:0]                   ddr3_dout,
   input  logic                         ddr3_ready,
   output logic [27:0]                  ddr3_addr,
   output logic                         ddr3_rd,
   output logic                         reset_rq,
   output msx_loader_pkg::bios_config_t bios_config,
   output logic                         fill_start,
   output msx_loader_pkg::fill_cmd_t    fill_cmd,
   input  logic                         need_byte,
   input  logic                         fill_done,
   output logic                         byte_valid,
   output logic [7:0]                   fill_byte,
   output logic                         slot_store,
   output msx_loader_pkg::slot_cmd_t    slot_cmd,
   output logic                         slot_clear,
   input  logic                         clear_done
);
   import msx_loader_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CLEAR,
      ST_READ_HDR,
      ST_CHECK,
      ST_FILL,
      ST_STORE
   } state_t;

   state_t     state;
   logic [7:0] hdr [16];
   logic [3:0] hdr_idx;
   logic       rd_pending;   // read issued but byte not taken yet
   logic [3:0] ref_ram;
   data_id_t   data_id;
   logic       has_data;
   logic       ddr3_free;

   assign ddr3_free  = ddr3_ready & ~ddr3_rd;
   assign reset_rq   = state != ST_IDLE;
   assign data_id    = data_id_t'(hdr[4]);
   assign has_data   = data_id != ID_NONE;
   assign byte_valid = (state == ST_FILL) & rd_pending & ddr3_free;
   assign fill_byte  = ddr3_dout;

   assign fill_cmd = '{
      size_units: has_data ? {hdr[5][2:0], hdr[6]} : 11'd0,
      pattern:    hdr[11][2:0],
      copy:       data_id != ID_RAM,
      ref_ram:    ref_ram
   };

   assign slot_cmd = '{
      slot_subslot: hdr[3][3:0],
      mode:         hdr[9],
      param:        hdr[10],
      mapper:       hdr[8],
      device:       hdr[7],
      ref_ram:      ref_ram,
      has_data:     has_data
   };

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= ST_IDLE;
         ddr3_rd    <= 1'b0;
         ddr3_addr  <= 28'd0;
         rd_pending <= 1'b0;
         hdr_idx    <= 4'd0;
         ref_ram    <= 4'd0;
         fill_start <= 1'b0;
         slot_store <= 1'b0;
         slot_clear <= 1'b0;
      end else begin
         fill_start <= 1'b0;
         slot_store <= 1'b0;
         slot_clear <= 1'b0;
         if (ddr3_rd & ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 28'd1;
         end
         if (load) begin
            state       <= ST_CLEAR;
            slot_clear  <= 1'b1;
            ddr3_addr   <= 28'd0;
            rd_pending  <= 1'b0;
            hdr_idx     <= 4'd0;
            ref_ram     <= 4'd0;
            bios_config <= '0;
         end else begin
            case (state)
               ST_CLEAR: begin
                  if (clear_done) begin
                     state <= ST_READ_HDR;
                  end
               end
               ST_READ_HDR: begin
                  if (ddr3_free) begin
                     if (!rd_pending) begin
                        if (ddr3_addr >= {1'b0, image_size}) begin
                           state <= ST_IDLE;   // whole image walked
                        end else begin
                           ddr3_rd    <= 1'b1;
                           rd_pending <= 1'b1;
                        end
                     end else begin
                        hdr[hdr_idx] <= ddr3_dout;
                        hdr_idx      <= hdr_idx + 4'd1;
                        if (hdr_idx == 4'd15) begin
                           rd_pending <= 1'b0;
                           state      <= ST_CHECK;
                        end else begin
                           ddr3_rd <= 1'b1;   // prefetch next byte
                        end
                     end
                  end
               end
               ST_CHECK: begin
                  state <= ST_READ_HDR;
                  if ({hdr[0], hdr[1], hdr[2]} != MAGIC) begin
                     state <= ST_IDLE;
                  end else begin
                     case (rec_kind_t'(hdr[3][7:4]))
                        REC_KBD_LAYOUT: ddr3_addr <= ddr3_addr + 28'(KBD_SKIP);
                        REC_CONFIG: begin
                           bios_config.slot_expander_en <= hdr[4][3:0];
                           bios_config.msx_typ          <= hdr[4][5:4];
                        end
                        REC_INTERNAL: begin
                           if (data_id == ID_RAM && bios_config.ram_size < hdr[6]) begin
                              bios_config.ram_size <= hdr[6];
                           end
                           fill_start <= 1'b1;
                           state      <= ST_FILL;
                        end
                        default: ;
                     endcase
                  end
               end
               ST_FILL: begin
                  if (fill_done) begin
                     slot_store <= 1'b1;
                     state      <= ST_STORE;
                  end else if (ddr3_free) begin
                     if (rd_pending) begin
                        rd_pending <= 1'b0;   // handed over on byte_valid
                     end else if (need_byte) begin
                        ddr3_rd    <= 1'b1;
                        rd_pending <= 1'b1;
                     end
                  end
               end
               ST_STORE: begin
                  ref_ram <= ref_ram + 4'(fill_cmd.size_units != 11'd0);
                  state   <= ST_READ_HDR;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/slot_table.sv ====
`default_nettype none

module slot_table (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        slot_clear,
   input  logic                        slot_store,
   input  msx_loader_pkg::slot_cmd_t   slot_cmd,
   output logic                        clear_done,
   output msx_loader_pkg::slot_block_t slot_layout [64]
);
   import msx_loader_pkg::*;

   localparam slot_block_t cleared_blk = '{
      mapper:     MAPPER_UNUSED,
      device:     DEVICE_NONE,
      ref_ram:    4'd0,
      offset_ram: 2'd0
   };

   logic        clearing;
   logic [5:0]  clr_idx;
   logic [3:0]  ref_sel;
   slot_block_t next_blk [4];

   assign ref_sel = slot_cmd.has_data ? slot_cmd.ref_ram : 4'd0;

   // new value of each block of the addressed slot/subslot from the old table
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         case (slot_cmd.mode[2*b +: 2])
            2'd1: next_blk[b] = slot_layout[{slot_cmd.slot_subslot, slot_cmd.param[2*b +: 2]}];
            2'd2: next_blk[b] = '{slot_cmd.mapper, slot_cmd.device, ref_sel,
                                  slot_cmd.param[2*b +: 2]};
            2'd3: next_blk[b] = '{MAPPER_UNUSED, slot_cmd.device, ref_sel,
                                  slot_cmd.param[2*b +: 2]};
            default: next_blk[b] = slot_layout[{slot_cmd.slot_subslot, 2'(b)}];
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clearing   <= 1'b0;
         clr_idx    <= 6'd0;
         clear_done <= 1'b0;
      end else begin
         clear_done <= clearing & (clr_idx == 6'd63);
         if (slot_clear) begin
            clearing <= 1'b1;
            clr_idx  <= 6'd0;
         end else if (clearing) begin
            clr_idx <= clr_idx + 6'd1;
            if (clr_idx == 6'd63) begin
               clearing <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clearing) begin
         slot_layout[clr_idx] <= cleared_blk;  // one entry per cycle
      end else if (slot_store) begin
         for (int b = 0; b < 4; b++) begin
            slot_layout[{slot_cmd.slot_subslot, 2'(b)}] <= next_blk[b];
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/upload_tracker.sv ====
`default_nettype none

module upload_tracker (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic [26:0] ioctl_addr,
   output logic [26:0] image_size,
   output logic        load
);

   logic download_q;
   logic image_done;

   // config image upload just ended
   assign image_done = download_q & ~ioctl_download & (ioctl_index[5:0] == 6'd1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         download_q <= 1'b0;
         load       <= 1'b0;
      end else begin
         download_q <= ioctl_download;
         load       <= image_done;
      end
   end

   always_ff @(posedge clk) begin
      if (image_done) begin
         image_size <= ioctl_addr;  // final address is the byte count
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/msx_loader_pkg.sv
src/upload_tracker.sv
src/slot_table.sv
src/fill_engine.sv
src/record_walker.sv
src/memory_loader.sv
dv/memory_loader_properties.sv
dv/memory_loader_tb.sv
